//--- char_fetch.sv
`timescale 1ns/10ps
`include "text_config.svh"

module char_fetch (
   input  logic                 clk,
   input  logic                 rst_n,
   field_hit_if.dst             hit,
   input  text_pkg::poke_id_t   poke_id,
   input  text_pkg::hp_t        cur_hp,
   input  text_pkg::hp_t        max_hp,
   output logic                 out_valid,
   input  logic                 out_ready,
   output logic                 is_text,
   output text_pkg::field_e     field,
   output text_pkg::char_t      char_code,
   output text_pkg::glyph_col_t bit_num,
   output text_pkg::glyph_row_t y_diff
);
   import text_pkg::*;

   // fixed labels, slot 0 leftmost
   localparam char_t [0:`TEXT_ENEMY_LEN-1] ENEMY_STR = "ENEMY ";
   localparam char_t [0:`TEXT_HPLBL_LEN-1] HPLBL_STR = "HP";
   localparam char_t [0:`TEXT_USED_LEN-1]  USED_STR  = "USED ";

   // index bits needed per field
   localparam int ENEMY_IW = $clog2(`TEXT_ENEMY_LEN);
   localparam int NAME_IW  = $clog2(`TEXT_NAME_LEN);
   localparam int HPLBL_IW = $clog2(`TEXT_HPLBL_LEN);
   localparam int HPVAL_IW = $clog2(`TEXT_HPVAL_LEN);
   localparam int USED_IW  = $clog2(`TEXT_USED_LEN);

   char_t hp_chars [`TEXT_HPVAL_LEN];
   char_t next_char;

   hp_digits u_hp_digits (
      .cur_hp   (cur_hp),
      .max_hp   (max_hp),
      .hp_chars (hp_chars)
   );

   // slot is always inside the field, locator guarantees it
   always_comb begin
      case (hit.field)
         FIELD_ENEMY: next_char = ENEMY_STR[hit.char_idx[ENEMY_IW-1:0]];
         FIELD_NAME:  next_char = NAME_TABLE[poke_id][hit.char_idx[NAME_IW-1:0]];
         FIELD_HPLBL: next_char = HPLBL_STR[hit.char_idx[HPLBL_IW-1:0]];
         FIELD_HPVAL: next_char = hp_chars[hit.char_idx[HPVAL_IW-1:0]];
         FIELD_USED:  next_char = USED_STR[hit.char_idx[USED_IW-1:0]];
         // nothing to draw
         default:     next_char = `TEXT_ASCII_SPACE;
      endcase
   end

   // output register empty or being taken
   assign hit.ready = !out_valid || out_ready;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         out_valid <= 1'b0;
      end else if (hit.ready) begin
         out_valid <= hit.valid;
      end
   end

   // result held stable while the sink stalls
   always_ff @(posedge clk) begin
      if (hit.valid && hit.ready) begin
         is_text   <= (hit.field != FIELD_NONE);
         field     <= hit.field;
         char_code <= next_char;
         bit_num   <= hit.bit_num;
         y_diff    <= hit.row;
      end
   end

endmodule

//--- field_hit_if.sv
`timescale 1ns/10ps

interface field_hit_if;
   import text_pkg::*;

   // handshake, transfer when both high
   logic       valid;
   logic       ready;

   // located pixel
   field_e     field;
   char_idx_t  char_idx;
   glyph_col_t bit_num;
   glyph_row_t row;

   // locator side
   modport src (
      output valid,
      input  ready,
      output field,
      output char_idx,
      output bit_num,
      output row
   );

   // fetch side
   modport dst (
      input  valid,
      output ready,
      input  field,
      input  char_idx,
      input  bit_num,
      input  row
   );

endinterface

//--- field_locator.sv
`timescale 1ns/10ps
`include "text_config.svh"

module field_locator (
   input  logic             clk,
   input  logic             rst_n,
   input  logic             pix_valid,
   output logic             pix_ready,
   input  text_pkg::coord_t draw_x,
   input  text_pkg::coord_t draw_y,
   field_hit_if.src         hit
);
   import text_pkg::*;

   // stage register holds a pixel
   logic   full;

   // origin of the field that covers the pixel
   field_e sel_field;
   coord_t org_x;
   coord_t org_y;
   coord_t dx;
   coord_t dy;

   // one glyph row high, len glyphs wide
   function automatic logic in_rect(input coord_t x, input coord_t y,
                                    input int ox, input int oy, input int len);
      return (int'(y) >= oy) && (int'(y) < oy + `TEXT_GLYPH_H) &&
             (int'(x) >= ox) && (int'(x) < ox + `TEXT_GLYPH_W * len);
   endfunction

   // fields never overlap so the order is arbitrary
   always_comb begin
      sel_field = FIELD_NONE;
      org_x     = '0;
      org_y     = '0;
      if (in_rect(draw_x, draw_y, `TEXT_ENEMY_X, `TEXT_ENEMY_Y, `TEXT_ENEMY_LEN)) begin
         sel_field = FIELD_ENEMY;
         org_x     = coord_t'(`TEXT_ENEMY_X);
         org_y     = coord_t'(`TEXT_ENEMY_Y);
      end else if (in_rect(draw_x, draw_y, `TEXT_NAME_X, `TEXT_NAME_Y, `TEXT_NAME_LEN)) begin
         sel_field = FIELD_NAME;
         org_x     = coord_t'(`TEXT_NAME_X);
         org_y     = coord_t'(`TEXT_NAME_Y);
      end else if (in_rect(draw_x, draw_y, `TEXT_HPLBL_X, `TEXT_HPLBL_Y, `TEXT_HPLBL_LEN)) begin
         sel_field = FIELD_HPLBL;
         org_x     = coord_t'(`TEXT_HPLBL_X);
         org_y     = coord_t'(`TEXT_HPLBL_Y);
      end else if (in_rect(draw_x, draw_y, `TEXT_HPVAL_X, `TEXT_HPVAL_Y, `TEXT_HPVAL_LEN)) begin
         sel_field = FIELD_HPVAL;
         org_x     = coord_t'(`TEXT_HPVAL_X);
         org_y     = coord_t'(`TEXT_HPVAL_Y);
      end else if (in_rect(draw_x, draw_y, `TEXT_USED_X, `TEXT_USED_Y, `TEXT_USED_LEN)) begin
         sel_field = FIELD_USED;
         org_x     = coord_t'(`TEXT_USED_X);
         org_y     = coord_t'(`TEXT_USED_Y);
      end
   end

   // offsets from the field origin
   assign dx = draw_x - org_x;
   assign dy = draw_y - org_y;

   // take a new pixel when empty or when the fetch stage drains us
   assign pix_ready = !full || hit.ready;
   assign hit.valid = full;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         full <= 1'b0;
      end else if (pix_ready) begin
         full <= pix_valid;
      end
   end

   // payload, held while stalled
   always_ff @(posedge clk) begin
      if (pix_valid && pix_ready) begin
         hit.field <= sel_field;
         if (sel_field != FIELD_NONE) begin
            // glyph width is a power of two, slot and column are a bit split
            hit.char_idx <= char_idx_t'(dx / `TEXT_GLYPH_W);
            hit.bit_num  <= glyph_col_t'(dx % `TEXT_GLYPH_W);
            hit.row      <= glyph_row_t'(dy);
         end else begin
            hit.char_idx <= '0;
            hit.bit_num  <= '0;
            hit.row      <= '0;
         end
      end
   end

endmodule

//--- files.f
+incdir+.
text_pkg.sv
field_hit_if.sv
field_locator.sv
hp_digits.sv
char_fetch.sv
text_overlay.sv
tb_text_overlay.sv

//--- hp_digits.sv
`timescale 1ns/10ps
`include "text_config.svh"

module hp_digits (
   input  text_pkg::hp_t   cur_hp,
   input  text_pkg::hp_t   max_hp,
   output text_pkg::char_t hp_chars [`TEXT_HPVAL_LEN]
);
   import text_pkg::*;

   // hundreds, tens, ones
   typedef char_t [0:2] hp_text_t;

   hp_text_t cur_txt;
   hp_text_t max_txt;

   // same rule for both halves of the readout
   function automatic hp_text_t hp_text(input hp_t v);
      hp_t      sat;
      hp_t      tens;
      hp_t      ones;
      hp_text_t txt;
      // out of range values pin at the top of the readout
      sat  = (v > `TEXT_HP_MAX) ? hp_t'(`TEXT_HP_MAX) : v;
      tens = (sat % 8'd100) / 8'd10;
      ones = sat % 8'd10;
      txt[0] = (sat >= 8'd100) ? `TEXT_ASCII_ONE : `TEXT_ASCII_SPACE;
      // leading zero blanked below 10
      txt[1] = (sat < 8'd100 && tens == 8'd0) ? `TEXT_ASCII_SPACE : `TEXT_ASCII_ZERO + tens;
      txt[2] = `TEXT_ASCII_ZERO + ones;
      return txt;
   endfunction

   assign cur_txt = hp_text(cur_hp);
   assign max_txt = hp_text(max_hp);

   // "ccc/mmm"
   assign hp_chars[0] = cur_txt[0];
   assign hp_chars[1] = cur_txt[1];
   assign hp_chars[2] = cur_txt[2];
   assign hp_chars[3] = `TEXT_ASCII_SLASH;
   assign hp_chars[4] = max_txt[0];
   assign hp_chars[5] = max_txt[1];
   assign hp_chars[6] = max_txt[2];

endmodule

//--- run.sh
#!/bin/sh
# build with verilator, run, and judge the run from its log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary -f files.f --top-module tb_text_overlay \
   && ./obj_dir/Vtb_text_overlay 2>&1 | tee sim.log \
   && grep -q "^Test completed successfully$" sim.log \
   && echo "simulation passed" \
   || { echo "simulation did not pass"; exit 1; }

//--- tb_text_overlay.sv
`timescale 1ns/10ps
`include "text_config.svh"

module tb_text_overlay;
   import text_pkg::*;

   // one expected output beat
   typedef struct packed {
      logic       is_text;
      field_e     field;
      char_t      char_code;
      glyph_col_t bit_num;
      glyph_row_t y_diff;
   } result_t;

   localparam int TIMEOUT = 2000;
   // origins and lengths indexed by the field enum value
   localparam int BOX_X [1:5] = '{`TEXT_ENEMY_X, `TEXT_NAME_X, `TEXT_HPLBL_X,
                                  `TEXT_HPVAL_X, `TEXT_USED_X};
   localparam int BOX_Y [1:5] = '{`TEXT_ENEMY_Y, `TEXT_NAME_Y, `TEXT_HPLBL_Y,
                                  `TEXT_HPVAL_Y, `TEXT_USED_Y};
   localparam int BOX_LEN [1:5] = '{`TEXT_ENEMY_LEN, `TEXT_NAME_LEN, `TEXT_HPLBL_LEN,
                                    `TEXT_HPVAL_LEN, `TEXT_USED_LEN};

   logic       clk;
   logic       rst_n;
   logic       pix_valid;
   logic       pix_ready;
   logic       out_valid;
   logic       is_text;
   logic       out_ready = 1'b1;
   coord_t     draw_x;
   coord_t     draw_y;
   poke_id_t   poke_id;
   hp_t        cur_hp;
   hp_t        max_hp;
   field_e     field;
   char_t      char_code;
   glyph_col_t bit_num;
   glyph_row_t y_diff;

   logic [31:0] lcg_state = 32'hc8af;
   logic [31:0] stall_state = 32'hc8af;
   result_t     exp_q [$];
   int          acc_q [$];
   result_t     held;
   bit          held_vld = 1'b0;
   bit          lat_check = 1'b0;
   int          cycle = 0;
   int          stall_pct = 0;
   int          hp_vals [7] = '{0, 7, 10, 99, 100, 150, 199};
   string       names [8] = '{"BLASTOISE", "CHARIZARD", "DRAGONITE", "GENGAR   ",
                              "MEW      ", "PIKACHU  ", "VENUSAUR ", "WEEZING  "};

   text_overlay dut0 (.*);

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   // one step of the lcg
   function automatic logic [31:0] lcg_next(input logic [31:0] s);
      return s * 32'd1664525 + 32'd1013904223;
   endfunction

   function automatic int rand_below(input int n);
      lcg_state = lcg_next(lcg_state);
      // upper half has the better period
      return int'(lcg_state >> 16) % n;
   endfunction

   // expected outputs for one pixel
   function automatic result_t ref_result(input int x, input int y, input int id,
                                          input int cur, input int maxv);
      result_t r;
      string   txt;
      r = '{1'b0, FIELD_NONE, 8'h20, 3'd0, 4'd0};
      for (int f = 1; f <= 5; f++) begin
         case (f)
            1: txt = "ENEMY ";
            2: txt = names[id];
            3: txt = "HP";
            // width 3 pads with spaces so leading zeros vanish
            4: txt = $sformatf("%3d/%3d", cur, maxv);
            default: txt = "USED ";
         endcase
         if (y >= BOX_Y[f] && y < BOX_Y[f] + `TEXT_GLYPH_H && x >= BOX_X[f] &&
             x < BOX_X[f] + `TEXT_GLYPH_W * txt.len()) begin
            r.is_text   = 1'b1;
            r.field     = field_e'(f);
            r.char_code = txt[(x - BOX_X[f]) / `TEXT_GLYPH_W];
            r.bit_num   = glyph_col_t'((x - BOX_X[f]) % `TEXT_GLYPH_W);
            r.y_diff    = glyph_row_t'(y - BOX_Y[f]);
         end
      end
      return r;
   endfunction

   task automatic fail_run(input string what);
      $display("%s at %0t", what, $time);
      $display("Test failed");
      $fatal(1, "%s", what);
   endtask

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      if (got !== exp) begin
         $display("FAIL time=%0t %s got=0x%0h expected=0x%0h", $time, name, got, exp);
         fail_run("output value mismatch");
      end
   endtask

   task automatic compare_outputs(input result_t e);
      check_value("is_text", 32'(is_text), 32'(e.is_text));
      check_value("field", 32'(field), 32'(e.field));
      check_value("char_code", 32'(char_code), 32'(e.char_code));
      check_value("bit_num", 32'(bit_num), 32'(e.bit_num));
      check_value("y_diff", 32'(y_diff), 32'(e.y_diff));
   endtask

   // hold the pixel until the DUT takes it
   task automatic send_pixel(input int x, input int y);
      int t;
      t = 0;
      pix_valid <= 1'b1;
      draw_x    <= coord_t'(x);
      draw_y    <= coord_t'(y);
      do begin
         @(posedge clk);
         t++;
         if (t > TIMEOUT)
            fail_run("timeout waiting for pix_ready");
      end while (!pix_ready);
      pix_valid <= 1'b0;
   endtask

   // half the pixels land inside a field after up to gap idle cycles
   task automatic send_random(input int gap);
      int f;
      repeat (rand_below(gap + 1)) @(posedge clk);
      f = 1 + rand_below(5);
      if (rand_below(2) == 0)
         send_pixel(BOX_X[f] + rand_below(8 * BOX_LEN[f]), BOX_Y[f] + rand_below(16));
      else
         send_pixel(rand_below(640), rand_below(480));
   endtask

   // status inputs only change with nothing in flight
   task automatic set_status(input int id, input int cur, input int maxv);
      int t;
      t = 0;
      // the queue only moves at rising edges
      do begin
         @(negedge clk);
         t++;
         if (t > TIMEOUT)
            fail_run("timeout waiting for the pipeline to drain");
      end while (exp_q.size() != 0);
      @(posedge clk);
      poke_id <= poke_id_t'(id);
      cur_hp  <= hp_t'(cur);
      max_hp  <= hp_t'(maxv);
   endtask

   // every slot once plus both corners and the pixels just outside
   task automatic sweep_field(input int f);
      for (int s = 0; s < BOX_LEN[f]; s++)
         send_pixel(BOX_X[f] + 8 * s + (s * 3) % 8, BOX_Y[f] + (s * 5) % 16);
      send_pixel(BOX_X[f], BOX_Y[f]);
      send_pixel(BOX_X[f] + 8 * BOX_LEN[f] - 1, BOX_Y[f] + 15);
      send_pixel(BOX_X[f] + 8 * BOX_LEN[f], BOX_Y[f]);
      send_pixel(BOX_X[f], BOX_Y[f] + 16);
   endtask

   // random sink stalls from a stream of their own
   always @(posedge clk) begin
      stall_state = lcg_next(stall_state);
      out_ready <= (int'(stall_state >> 16) % 100 >= stall_pct);
   end

   // scoreboard sees the pre-edge values of every handshake
   always @(posedge clk) begin
      if (rst_n) begin
         cycle++;
         if (held_vld)
            compare_outputs(held);
         held_vld = out_valid && !out_ready;
         held     = '{is_text, field, char_code, bit_num, y_diff};
         if (lat_check && pix_valid)
            check_value("pix_ready", 32'(pix_ready), 32'd1);
         if (pix_valid && pix_ready) begin
            exp_q.push_back(ref_result(int'(draw_x), int'(draw_y), int'(poke_id),
                                       int'(cur_hp), int'(max_hp)));
            acc_q.push_back(cycle);
         end
         if (out_valid && out_ready) begin
            if (exp_q.size() == 0)
               fail_run("result without an accepted pixel");
            compare_outputs(exp_q.pop_front());
            if (lat_check)
               check_value("latency", 32'(cycle - acc_q[0]), 32'd2);
            void'(acc_q.pop_front());
         end
      end
   end

   initial begin
      rst_n     = 1'b0;
      pix_valid = 1'b0;
      draw_x    = '0;
      draw_y    = '0;
      poke_id   = '0;
      cur_hp    = '0;
      max_hp    = '0;
      repeat (8) @(posedge clk);
      rst_n <= 1'b1;
      @(posedge clk);
      // idle pipeline after reset
      check_value("out_valid", 32'(out_valid), 32'd0);
      check_value("pix_ready", 32'(pix_ready), 32'd1);
      // fixed labels and empty screen
      set_status(0, 45, 120);
      sweep_field(1);
      sweep_field(3);
      sweep_field(5);
      send_pixel(0, 0);
      send_pixel(639, 479);
      // every creature name
      for (int id = 0; id < 8; id++) begin
         set_status(id, 45, 120);
         sweep_field(2);
      end
      // hit point corner values then random pairs
      for (int i = 0; i < 7; i++) begin
         set_status(i, hp_vals[i], hp_vals[(i + 3) % 7]);
         sweep_field(4);
      end
      for (int i = 0; i < 10; i++) begin
         set_status(i, rand_below(`TEXT_HP_MAX + 1), rand_below(`TEXT_HP_MAX + 1));
         sweep_field(4);
      end
      // back-pressure with source gaps
      stall_pct <= 40;
      for (int i = 0; i < 400; i++) begin
         if (i % 50 == 0)
            set_status(rand_below(8), rand_below(200), rand_below(200));
         send_random(3);
      end
      // full rate stream with the sink always ready
      set_status(5, 88, 150);
      stall_pct <= 0;
      repeat (2) @(posedge clk);
      lat_check <= 1'b1;
      for (int i = 0; i < 24; i++)
         send_random(0);
      set_status(5, 88, 150);
      lat_check <= 1'b0;
      repeat (4) @(posedge clk);
      if (exp_q.size() == 0 && !out_valid) begin
         $display("Test completed successfully");
         $finish;
      end else begin
         fail_run("results left in flight at the end of the run");
      end
   end

endmodule

//--- text_config.svh
`ifndef TEXT_CONFIG_SVH
`define TEXT_CONFIG_SVH

// screen coordinate width, 640x480 fits in 10 bits
`define TEXT_COORD_W     10

// glyph cell of the font rom
`define TEXT_GLYPH_W     8
`define TEXT_GLYPH_H     16

// creature name table
`define TEXT_NAME_LEN    9
`define TEXT_NAME_COUNT  8

// readout covers 0..199 only, hundreds digit is blank or '1'
`define TEXT_HP_MAX      199

// ascii codes
`define TEXT_ASCII_SPACE 8'h20
`define TEXT_ASCII_ZERO  8'h30
`define TEXT_ASCII_ONE   8'h31
`define TEXT_ASCII_SLASH 8'h2F

// field origins, top left pixel of the first glyph
`define TEXT_ENEMY_X     16
`define TEXT_ENEMY_Y     16
`define TEXT_NAME_X      64
`define TEXT_NAME_Y      16
`define TEXT_HPLBL_X     16
`define TEXT_HPLBL_Y     40
`define TEXT_HPVAL_X     40
`define TEXT_HPVAL_Y     40
`define TEXT_USED_X      16
`define TEXT_USED_Y      440

// field lengths in characters
`define TEXT_ENEMY_LEN   6
`define TEXT_HPLBL_LEN   2
`define TEXT_HPVAL_LEN   7
`define TEXT_USED_LEN    5

`endif

//--- text_overlay.sv
`timescale 1ns/10ps

module text_overlay (
   input  logic                 clk,
   input  logic                 rst_n,
   // pixel source
   input  logic                 pix_valid,
   output logic                 pix_ready,
   input  text_pkg::coord_t     draw_x,
   input  text_pkg::coord_t     draw_y,
   // battle status, stable while pixels are in flight
   input  text_pkg::poke_id_t   poke_id,
   input  text_pkg::hp_t        cur_hp,
   input  text_pkg::hp_t        max_hp,
   // towards the font rom
   output logic                 out_valid,
   input  logic                 out_ready,
   output logic                 is_text,
   output text_pkg::field_e     field,
   output text_pkg::char_t      char_code,
   output text_pkg::glyph_col_t bit_num,
   output text_pkg::glyph_row_t y_diff
);

   // stage 1 to stage 2
   field_hit_if hit_if ();

   // stage 1, field and slot lookup
   field_locator u_field_locator (
      .clk       (clk),
      .rst_n     (rst_n),
      .pix_valid (pix_valid),
      .pix_ready (pix_ready),
      .draw_x    (draw_x),
      .draw_y    (draw_y),
      .hit       (hit_if.src)
   );

   // stage 2, character select
   char_fetch u_char_fetch (
      .clk       (clk),
      .rst_n     (rst_n),
      .hit       (hit_if.dst),
      .poke_id   (poke_id),
      .cur_hp    (cur_hp),
      .max_hp    (max_hp),
      .out_valid (out_valid),
      .out_ready (out_ready),
      .is_text   (is_text),
      .field     (field),
      .char_code (char_code),
      .bit_num   (bit_num),
      .y_diff    (y_diff)
   );

endmodule

//--- text_pkg.sv
`include "text_config.svh"

package text_pkg;

   // pixel position on screen
   typedef logic [`TEXT_COORD_W-1:0] coord_t;

   // one ascii code for the font rom
   typedef logic [7:0] char_t;

   // position inside a glyph cell
   typedef logic [2:0] glyph_col_t;
   typedef logic [3:0] glyph_row_t;

   // character slot in a field, longest field is 9
   typedef logic [3:0] char_idx_t;

   typedef logic [2:0] poke_id_t;
   typedef logic [7:0] hp_t;

   // which text field covers the pixel
   typedef enum logic [2:0] {
      FIELD_NONE,
      FIELD_ENEMY,
      FIELD_NAME,
      FIELD_HPLBL,
      FIELD_HPVAL,
      FIELD_USED
   } field_e;

   // creature names, space padded
   // slot 0 is the leftmost character
   localparam char_t [0:`TEXT_NAME_LEN-1] NAME_TABLE [`TEXT_NAME_COUNT] = '{
      "BLASTOISE",
      "CHARIZARD",
      "DRAGONITE",
      "GENGAR   ",
      "MEW      ",
      "PIKACHU  ",
      "VENUSAUR ",
      "WEEZING  "
   };

endpackage
